//--- include/ddc_cfg.svh
`ifndef DDC_CFG_SVH
`define DDC_CFG_SVH

`define DDC_ADDR_W      12
`define DDC_BUS_W       32
`define DDC_ADC_W       16
`define DDC_IQ_W        24 // i/q rail width through the chain.
`define DDC_PHASE_W     32
`define DDC_LUT_BITS    8  // two quadrant bits plus table index.
`define DDC_MAX_DECIM   16

// register map.
`define DDC_CENTER_FREQ 12'h000
`define DDC_CONTROL     12'h004
`define DDC_DECIMATION  12'h008

`endif

//--- source/ddcRegPkg.sv
`include "ddc_cfg.svh"

package ddcRegPkg;

    typedef struct packed {
        logic [`DDC_ADDR_W-1:0]   addr;
        logic [`DDC_BUS_W-1:0]    dataIn;
        logic                     cs;
        logic [`DDC_BUS_W/8-1:0]  wr;     // one strobe per byte lane.
    } regBus_t;

    typedef struct packed {
        logic [`DDC_BUS_W-4:0] reserved;
        logic                  bypassFir;
        logic                  bypassHb;
        logic                  bypassCic; // bit 0.
    } ctrlFields_t;

    typedef union packed {
        logic [`DDC_BUS_W-1:0] raw;
        ctrlFields_t           fields;
    } ctrlWord_u;

    typedef struct packed {
        logic [`DDC_PHASE_W-1:0] centerFreq;
        ctrlWord_u               ctrl;
        logic [7:0]              decimation;
    } ddcCfg_t;

endpackage

//--- source/ddcDspPkg.sv
`include "ddc_cfg.svh"

package ddcDspPkg;

    typedef struct packed {
        logic signed [`DDC_IQ_W-1:0] i;
        logic signed [`DDC_IQ_W-1:0] q;
    } iqSample_t;

    // stage to stage link, valid is a one-cycle strobe.
    typedef struct packed {
        logic      valid;
        iqSample_t data;
    } iqStream_t;

endpackage

//--- source/ddcRegs.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module ddcRegs (
    input  logic                   clk,
    input  logic                   rstN,
    input  ddcRegPkg::regBus_t     bus,
    output logic [`DDC_BUS_W-1:0]  dataOut,
    output ddcRegPkg::ddcCfg_t     cfg
);
    localparam int busW = `DDC_BUS_W;

    logic [busW-1:0]      centerFreq;
    ddcRegPkg::ctrlWord_u ctrl;
    logic [7:0]           decimation;
    logic                 decimOk;

    assign decimOk = (bus.dataIn[7:0] >= 8'd1) && (bus.dataIn[7:0] <= 8'(`DDC_MAX_DECIM));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            centerFreq <= '0;
            ctrl.raw   <= '0;
            decimation <= 8'd1;
        end else if (bus.cs) begin
            case (bus.addr)
                `DDC_CENTER_FREQ: begin
                    for (int lane = 0; lane < busW / 8; lane++) begin
                        if (bus.wr[lane]) begin
                            centerFreq[lane*8 +: 8] <= bus.dataIn[lane*8 +: 8];
                        end
                    end
                end
                `DDC_CONTROL: begin
                    if (bus.wr[0]) begin
                        ctrl.raw <= {{(busW-3){1'b0}}, bus.dataIn[2:0]}; // bypass bits only.
                    end
                end
                `DDC_DECIMATION: begin
                    if (bus.wr[0] && decimOk) begin
                        decimation <= bus.dataIn[7:0];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = '0;
        if (bus.cs) begin
            case (bus.addr)
                `DDC_CENTER_FREQ: dataOut = centerFreq;
                `DDC_CONTROL:     dataOut = ctrl.raw;
                `DDC_DECIMATION:  dataOut = {{(busW-8){1'b0}}, decimation};
                default:          dataOut = '0;
            endcase
        end
    end

    assign cfg = '{centerFreq: centerFreq, ctrl: ctrl, decimation: decimation};

    assert property (@(posedge clk) disable iff (!rstN)
        (decimation >= 8'd1) && (decimation <= 8'(`DDC_MAX_DECIM)));

endmodule

//--- source/ncoMixer.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module ncoMixer (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [`DDC_PHASE_W-1:0]       centerFreq,
    input  logic signed [`DDC_ADC_W-1:0]  adcSample,
    input  logic                          sampleValid,
    output ddcDspPkg::iqStream_t          out
);
    localparam int iqW = `DDC_IQ_W;
    localparam int lutBits = `DDC_LUT_BITS;
    localparam int quarterLen = 1 << (lutBits - 2);

    typedef logic [15:0] quarterTable_t [0:quarterLen];

    // sine over one quadrant, both end points included.
    function automatic quarterTable_t buildTable();
        quarterTable_t t;
        for (int k = 0; k <= quarterLen; k++) begin
            t[k] = 16'($rtoi($sin(k * 3.14159265358979 / (2.0 * quarterLen)) * 32767.0 + 0.5));
        end
        return t;
    endfunction

    localparam quarterTable_t sinTable = buildTable();

    function automatic logic signed [15:0] sinLookup(input logic [lutBits-1:0] ph);
        logic [lutBits-3:0] idx;
        logic [15:0]        mag;
        idx = ph[lutBits-3:0];
        mag = ph[lutBits-2] ? sinTable[quarterLen - idx] : sinTable[idx]; // odd quadrant mirrors.
        return ph[lutBits-1] ? -$signed(mag) : $signed(mag);
    endfunction

    logic [`DDC_PHASE_W-1:0]         phase;
    logic [lutBits-1:0]              lutPhase;
    logic signed [15:0]              cosVal;
    logic signed [15:0]              sinVal;
    logic signed [2*`DDC_ADC_W-1:0]  prodI;
    logic signed [2*`DDC_ADC_W-1:0]  prodQ;
    logic                            outValid;
    ddcDspPkg::iqSample_t            outData;

    assign lutPhase = phase[`DDC_PHASE_W-1 -: lutBits];
    assign sinVal   = sinLookup(lutPhase);
    assign cosVal   = sinLookup(lutPhase + lutBits'(quarterLen)); // cos is sin a quadrant ahead.
    assign prodI    = adcSample * cosVal;
    assign prodQ    = -(adcSample * sinVal);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= sampleValid;
            if (sampleValid) begin
                phase <= phase + centerFreq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            outData.i <= iqW'(prodI >>> 15);
            outData.q <= iqW'(prodQ >>> 15);
        end
    end

    assign out = '{valid: outValid, data: outData};

endmodule

//--- source/cicDecimator.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module cicDecimator (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [7:0]            decimation,
    input  logic                  bypass,
    input  ddcDspPkg::iqStream_t  in,
    output ddcDspPkg::iqStream_t  out
);
    localparam int iqW = `DDC_IQ_W;
    localparam int accW = iqW + 2 * $clog2(`DDC_MAX_DECIM); // growth for two stages.

    logic signed [iqW-1:0]  x [2];
    logic signed [accW-1:0] integ1 [2];
    logic signed [accW-1:0] integ2 [2];
    logic signed [accW-1:0] integ1Next [2];
    logic signed [accW-1:0] integ2Next [2];
    logic signed [accW-1:0] combDly1 [2];
    logic signed [accW-1:0] combDly2 [2];
    logic signed [accW-1:0] comb1 [2];
    logic signed [accW-1:0] comb2 [2];
    logic [7:0]             count;
    logic                   emit;
    logic                   outValid;
    ddcDspPkg::iqSample_t   outData;

    assign x[0] = in.data.i;
    assign x[1] = in.data.q;
    assign emit = in.valid && (count >= decimation - 8'd1);

    always_comb begin
        for (int r = 0; r < 2; r++) begin
            integ1Next[r] = integ1[r] + x[r];
            integ2Next[r] = integ2[r] + integ1Next[r];
            comb1[r]      = integ2Next[r] - combDly1[r]; // low-rate combs.
            comb2[r]      = comb1[r] - combDly2[r];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < 2; r++) begin
                integ1[r]   <= '0;
                integ2[r]   <= '0;
                combDly1[r] <= '0;
                combDly2[r] <= '0;
            end
            count    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= bypass ? in.valid : emit;
            if (in.valid) begin
                count <= emit ? 8'd0 : count + 8'd1;
                for (int r = 0; r < 2; r++) begin
                    integ1[r] <= integ1Next[r];
                    integ2[r] <= integ2Next[r];
                    if (emit) begin
                        combDly1[r] <= integ2Next[r];
                        combDly2[r] <= comb1[r];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bypass && in.valid) begin
            outData <= in.data;
        end else if (emit) begin
            outData.i <= comb2[0][iqW-1:0];
            outData.q <= comb2[1][iqW-1:0];
        end
    end

    assign out = '{valid: outValid, data: outData};

    assert property (@(posedge clk) disable iff (!rstN) out.valid |-> $past(in.valid));

endmodule

//--- source/halfbandDecimator.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module halfbandDecimator (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  bypass,
    input  ddcDspPkg::iqStream_t  in,
    output ddcDspPkg::iqStream_t  out
);
    localparam int iqW = `DDC_IQ_W;
    localparam int accW = iqW + 8;

    logic signed [iqW-1:0]  x [2];
    logic signed [iqW-1:0]  line [2][6];  // taps 1..6, tap 0 is the input.
    logic signed [accW-1:0] acc [2];
    logic                   phase;
    logic                   emit;
    logic                   outValid;
    ddcDspPkg::iqSample_t   outData;

    assign x[0] = in.data.i;
    assign x[1] = in.data.q;
    assign emit = in.valid && phase;

    always_comb begin
        for (int r = 0; r < 2; r++) begin
            acc[r] = -2 * (x[r] + line[r][5]) + 18 * (line[r][1] + line[r][3])
                   + 32 * line[r][2];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase    <= 1'b0;
            outValid <= 1'b0;
        end else begin
            outValid <= bypass ? in.valid : emit;
            if (in.valid) begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            for (int r = 0; r < 2; r++) begin
                line[r][0] <= x[r];
                for (int k = 1; k < 6; k++) begin
                    line[r][k] <= line[r][k-1];
                end
            end
            if (bypass) begin
                outData <= in.data;
            end else if (phase) begin
                outData.i <= iqW'(acc[0] >>> 6); // taps sum to 64.
                outData.q <= iqW'(acc[1] >>> 6);
            end
        end
    end

    assign out = '{valid: outValid, data: outData};

    assert property (@(posedge clk) disable iff (!rstN)
        (!$past(bypass) && !bypass && out.valid) |=> !out.valid);

endmodule

//--- source/firCompensator.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module firCompensator (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  bypass,
    input  ddcDspPkg::iqStream_t  in,
    output ddcDspPkg::iqStream_t  out
);
    localparam int iqW = `DDC_IQ_W;
    localparam int accW = iqW + 8;

    logic signed [iqW-1:0]  x [2];
    logic signed [iqW-1:0]  line [2][4];
    logic signed [accW-1:0] acc [2];
    logic                   outValid;
    ddcDspPkg::iqSample_t   outData;

    assign x[0] = in.data.i;
    assign x[1] = in.data.q;

    // folded symmetric taps.
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            acc[r] = -3 * (x[r] + line[r][3]) - 5 * (line[r][0] + line[r][2])
                   + 80 * line[r][1];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= in.valid; // full rate.
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            for (int r = 0; r < 2; r++) begin
                line[r][0] <= x[r];
                for (int k = 1; k < 4; k++) begin
                    line[r][k] <= line[r][k-1];
                end
            end
            if (bypass) begin
                outData <= in.data;
            end else begin
                outData.i <= iqW'(acc[0] >>> 6);
                outData.q <= iqW'(acc[1] >>> 6);
            end
        end
    end

    assign out = '{valid: outValid, data: outData};

endmodule

//--- source/ddcTop.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module ddcTop (
    input  logic                          clk,
    input  logic                          rstN,
    input  ddcRegPkg::regBus_t            bus,
    output logic [`DDC_BUS_W-1:0]         dataOut,
    input  logic signed [`DDC_ADC_W-1:0]  adcSample,
    input  logic                          sampleValid,
    output ddcDspPkg::iqStream_t          outIq
);
    ddcRegPkg::ddcCfg_t   cfg;
    ddcDspPkg::iqStream_t mixOut;
    ddcDspPkg::iqStream_t cicOut;
    ddcDspPkg::iqStream_t hbOut;

    ddcRegs regs (
        .clk(clk), .rstN(rstN), .bus(bus), .dataOut(dataOut), .cfg(cfg)
    );

    ncoMixer mixer (
        .clk(clk), .rstN(rstN), .centerFreq(cfg.centerFreq),
        .adcSample(adcSample), .sampleValid(sampleValid), .out(mixOut)
    );

    cicDecimator cic (
        .clk(clk), .rstN(rstN), .decimation(cfg.decimation),
        .bypass(cfg.ctrl.fields.bypassCic), .in(mixOut), .out(cicOut)
    );

    halfbandDecimator halfband (
        .clk(clk), .rstN(rstN), .bypass(cfg.ctrl.fields.bypassHb),
        .in(cicOut), .out(hbOut)
    );

    firCompensator fir (
        .clk(clk), .rstN(rstN), .bypass(cfg.ctrl.fields.bypassFir),
        .in(hbOut), .out(outIq)
    );

endmodule

//--- tests/ddcTb.sv
`timescale 1ns/1ps
`include "ddc_cfg.svh"

module ddcTb;
    localparam int clkPeriod = 100;
    localparam int resetCycles = 3;
    localparam int regRounds = 40;
    localparam int bypassLen = 64;
    localparam int ncoLen = 32;    // multiple of 4, phase returns to zero.
    localparam int cicOuts = 20;
    localparam int hbLen = 64;
    localparam int drainCycles = 8;
    localparam int seqCycles = resetCycles + 2 * regRounds + 24 + bypassLen + ncoLen
                             + `DDC_MAX_DECIM * cicOuts + hbLen + 4 * (6 + 2 * drainCycles);
    localparam int modeIdle = 0;
    localparam int modeStream = 1;
    localparam int modeSettle = 2;

    logic                         clk = 1'b0;
    logic                         rstN;
    ddcRegPkg::regBus_t           bus;
    logic [`DDC_BUS_W-1:0]        dataOut;
    logic signed [`DDC_ADC_W-1:0] adcSample;
    logic                         sampleValid;
    ddcDspPkg::iqStream_t         outIq;

    logic [31:0]          regModel [3]; // centre freq, control, decimation.
    logic [31:0]          phaseModel;
    logic                 readCheck;
    logic [31:0]          readExp;
    int                   mode;
    ddcDspPkg::iqSample_t expQ [$];
    ddcDspPkg::iqSample_t expHead;
    logic                 expAvail;
    logic                 validSeen;
    ddcDspPkg::iqSample_t settleExp;
    int                   settleAfter;
    int                   totalOut;
    int                   startCount;

    ddcTop uut (
        .clk(clk), .rstN(rstN), .bus(bus), .dataOut(dataOut),
        .adcSample(adcSample), .sampleValid(sampleValid), .outIq(outIq)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic failRun();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // ideal mixer, exact at the quarter points.
    function automatic ddcDspPkg::iqSample_t mixModel(input int x, input logic [1:0] quad);
        int                   c;
        int                   s;
        ddcDspPkg::iqSample_t r;
        c = (quad == 2'd0) ? 32767 : (quad == 2'd2) ? -32767 : 0;
        s = (quad == 2'd1) ? 32767 : (quad == 2'd3) ? -32767 : 0;
        r.i = 24'((x * c) >>> 15);
        r.q = 24'((-x * s) >>> 15);
        return r;
    endfunction

    function automatic logic [31:0] regValue(input logic [11:0] addr);
        case (addr)
            `DDC_CENTER_FREQ: return regModel[0];
            `DDC_CONTROL:     return regModel[1];
            `DDC_DECIMATION:  return regModel[2];
            default:          return '0;
        endcase
    endfunction

    task automatic writeReg(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] wr);
        @(negedge clk);
        sampleValid = 1'b0;
        readCheck = 1'b0;
        bus = '{addr: addr, dataIn: data, cs: 1'b1, wr: wr};
        case (addr)
            `DDC_CENTER_FREQ: begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (wr[lane]) begin
                        regModel[0][lane*8 +: 8] = data[lane*8 +: 8];
                    end
                end
            end
            `DDC_CONTROL: begin
                if (wr[0]) begin
                    regModel[1] = {29'b0, data[2:0]}; // bypass bits only.
                end
            end
            `DDC_DECIMATION: begin
                if (wr[0] && data[7:0] >= 8'd1 && data[7:0] <= 8'(`DDC_MAX_DECIM)) begin
                    regModel[2] = {24'b0, data[7:0]};
                end
            end
            default: ;
        endcase
    endtask

    task automatic readReg(input logic [11:0] addr, input logic cs);
        @(negedge clk);
        sampleValid = 1'b0;
        bus = '{addr: addr, dataIn: 32'($urandom), cs: cs, wr: 4'b0};
        readExp = cs ? regValue(addr) : '0;
        readCheck = 1'b1;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            bus.cs = 1'b0;
            bus.wr = '0;
            sampleValid = 1'b0;
            readCheck = 1'b0;
        end
    endtask

    task automatic sendSample(input logic signed [15:0] x);
        @(negedge clk);
        bus.cs = 1'b0;
        bus.wr = '0;
        readCheck = 1'b0;
        adcSample = x;
        sampleValid = 1'b1;
        if (mode == modeStream) begin
            expQ.push_back(mixModel(x, phaseModel[31:30]));
        end
        phaseModel = phaseModel + regModel[0]; // mixer uses the old phase.
    endtask

    task automatic drainStream();
        while (expQ.size() > 0) begin
            idleCycles(1);
        end
        idleCycles(drainCycles);
    endtask

    task automatic runCounted(input int n, input int expected, input logic signed [15:0] x);
        startCount = totalOut;
        mode = modeSettle;
        repeat (n) sendSample(x);
        idleCycles(1);
        while (totalOut - startCount < expected) begin
            idleCycles(1);
        end
        idleCycles(drainCycles); // room for any extra outputs.
        assert (totalOut - startCount == expected)
            else begin
                $display("error at %0d ns: outIq.valid count = %0d, expected %0d",
                         $time, totalOut - startCount, expected);
                failRun();
            end
        mode = modeIdle;
    endtask

    // head of the expected stream, output checked at the last rising edge.
    always @(negedge clk) begin
        if (validSeen && expQ.size() > 0) begin
            void'(expQ.pop_front());
        end
        expAvail = (expQ.size() > 0);
        if (expAvail) begin
            expHead = expQ[0];
        end
    end

    always @(posedge clk) begin
        validSeen <= outIq.valid;
        if (outIq.valid) begin
            totalOut <= totalOut + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) readCheck |-> dataOut == readExp)
        else begin
            $display("error at %0d ns: dataOut = %h, expected %h",
                     $time, $sampled(dataOut), $sampled(readExp));
            failRun();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (mode == modeStream && outIq.valid) |-> expAvail)
        else begin
            $display("error at %0d ns: outIq.valid came with no input sample left to match",
                     $time);
            failRun();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (mode == modeStream && outIq.valid && expAvail) |-> outIq.data.i == expHead.i)
        else begin
            $display("error at %0d ns: outIq.data.i = %0d, expected %0d",
                     $time, $sampled(outIq.data.i), $sampled(expHead.i));
            failRun();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (mode == modeStream && outIq.valid && expAvail) |-> outIq.data.q == expHead.q)
        else begin
            $display("error at %0d ns: outIq.data.q = %0d, expected %0d",
                     $time, $sampled(outIq.data.q), $sampled(expHead.q));
            failRun();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (mode == modeSettle && outIq.valid && totalOut - startCount >= settleAfter)
        |-> outIq.data.i == settleExp.i)
        else begin
            $display("error at %0d ns: outIq.data.i = %0d, expected %0d",
                     $time, $sampled(outIq.data.i), $sampled(settleExp.i));
            failRun();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (mode == modeSettle && outIq.valid && totalOut - startCount >= settleAfter)
        |-> outIq.data.q == settleExp.q)
        else begin
            $display("error at %0d ns: outIq.data.q = %0d, expected %0d",
                     $time, $sampled(outIq.data.q), $sampled(settleExp.q));
            failRun();
        end

    initial begin
        #(seqCycles * clkPeriod * 3 / 2);
        $display("timeout: the test sequence did not finish within %0d cycles",
                 seqCycles * 3 / 2);
        failRun();
    end

    initial begin
        logic [31:0]        word;
        logic [3:0]         mask;
        logic signed [15:0] x;
        int                 r;
        void'($urandom(32));
        rstN = 1'b0;
        bus = '0;
        adcSample = '0;
        sampleValid = 1'b0;
        readCheck = 1'b0;
        readExp = '0;
        mode = modeIdle;
        expAvail = 1'b0;
        expHead = '0;
        validSeen = 1'b0;
        settleExp = '0;
        settleAfter = 0;
        totalOut = 0;
        startCount = 0;
        regModel[0] = '0;
        regModel[1] = '0;
        regModel[2] = 32'd1;
        phaseModel = '0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        // byte lanes and read-back.
        for (int k = 0; k < regRounds; k++) begin
            word = $urandom;
            mask = 4'($urandom);
            writeReg(`DDC_CENTER_FREQ, word, mask);
            readReg(`DDC_CENTER_FREQ, 1'b1);
        end
        writeReg(`DDC_CONTROL, $urandom, 4'hf);
        readReg(`DDC_CONTROL, 1'b1);
        writeReg(`DDC_DECIMATION, {24'($urandom), 8'd5}, 4'hf);
        readReg(`DDC_DECIMATION, 1'b1);

        // unmapped, cs low and out of range decimation.
        writeReg(12'h00c, $urandom, 4'hf);
        readReg(12'h00c, 1'b1);
        readReg(12'hffc, 1'b1);
        readReg(`DDC_CENTER_FREQ, 1'b0);
        readReg(`DDC_DECIMATION, 1'b0);
        writeReg(`DDC_DECIMATION, 32'd0, 4'h1);
        readReg(`DDC_DECIMATION, 1'b1);
        writeReg(`DDC_DECIMATION, 32'd17, 4'h1);
        readReg(`DDC_DECIMATION, 1'b1);
        writeReg(`DDC_DECIMATION, 32'd200, 4'h1);
        readReg(`DDC_DECIMATION, 1'b1);

        // full bypass at frequency zero.
        writeReg(`DDC_CENTER_FREQ, '0, 4'hf);
        writeReg(`DDC_CONTROL, 32'h7, 4'h1);
        mode = modeStream;
        for (int k = 0; k < bypassLen; k++) begin
            sendSample(16'($urandom));
        end
        drainStream();

        // quarter rate nco.
        writeReg(`DDC_CENTER_FREQ, 32'h4000_0000, 4'hf);
        x = 16'($urandom);
        repeat (ncoLen) sendSample(x);
        drainStream();
        mode = modeIdle;

        // cic alone, gain of r squared.
        r = 1 + int'($urandom % `DDC_MAX_DECIM);
        writeReg(`DDC_CENTER_FREQ, '0, 4'hf);
        writeReg(`DDC_DECIMATION, 32'(r), 4'h1);
        writeReg(`DDC_CONTROL, 32'h6, 4'h1);
        x = 16'($urandom);
        settleExp = mixModel(x, phaseModel[31:30]);
        settleExp.i = 24'(settleExp.i * r * r);
        settleExp.q = 24'(settleExp.q * r * r);
        settleAfter = 2; // both comb delays refilled.
        runCounted(r * cicOuts, cicOuts, x);

        // halfband and fir, unity dc gain.
        writeReg(`DDC_CONTROL, 32'h1, 4'h1);
        x = 16'($urandom);
        settleExp = mixModel(x, phaseModel[31:30]);
        settleAfter = 12;
        runCounted(hbLen, hbLen / 2, x);

        idleCycles(2);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/ddcRegPkg.sv
source/ddcDspPkg.sv
source/ddcRegs.sv
source/ncoMixer.sv
source/cicDecimator.sv
source/halfbandDecimator.sv
source/firCompensator.sv
source/ddcTop.sv
tests/ddcTb.sv

//--- run.sh
#!/bin/sh
# Build and run the DDC testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module ddcTb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build returned status $status"
    exit "$status"
fi

./obj_dir/VddcTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "testbench run returned status $status"
    exit "$status"
fi

exit 0
